//--- verif/cache_stim.txt
# op (L load, S store), byte address (hex), store data or expected load data (hex),
# hit flag (1 means done one cycle after acceptance, 0 means a miss)
L 00001004 5a5a1004 0
L 0000100c 5a5a100c 1
S 00001008 deadbeef 1
L 00001008 deadbeef 1
L 00002004 5a5a2004 0
S 00002000 12345678 1
L 00003008 5a5a3008 0
L 00001008 deadbeef 0
L 00002000 12345678 0
L 00001000 5a5a1000 1
S 00000054 cafef00d 0
L 00000054 cafef00d 1
L 00000050 5a5a0050 1
L 00002004 5a5a2004 1
L 00003008 5a5a3008 0
L 00002000 12345678 0
L fffffffc a5a5fffc 0
S fffffff0 0badf00d 1
L fffffff0 0badf00d 1
L 000000fc 5a5a00fc 0
L 000001f4 5a5a01f4 0
L fffffff0 0badf00d 0
L 00001003 5a5a1000 0
L 0000200c 5a5a200c 1

//--- all.f
rtl/cache_pkg.sv
rtl/beat_counter.sv
rtl/tag_store.sv
rtl/data_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
verif/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module cache_tb -f all.f -o cache_sim \
    && ./obj_dir/cache_sim \
    || { echo "cache build or run ended with an error" >&2; exit 1; }

//--- verif/cache_tb.sv
`timescale 1ns/10ps

module cache_tb;
    import cache_pkg::*;

    logic     clk;
    logic     rst_n;
    cpu_req_t req;
    logic     busy;
    logic     done;
    word_t    load_data;
    mem_cmd_t mem_cmd;
    logic     waitrequest;
    logic     readdatavalid;
    word_t    readdata;

    // Memory contents that differ from the fill pattern
    word_t       mem_model [addr_t];
    logic [7:0]  op_q [$];
    addr_t       addr_q [$];
    word_t       data_q [$];
    logic        hit_q [$];
    int          accepted = 0;
    int          done_count = 0;
    int          total_reads = 0;
    int          run_cycles = 0;
    int          cycle_limit = 0;

    cache_top #(.ways_w(1)) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .busy          (busy),
        .done          (done),
        .load_data     (load_data),
        .mem_cmd       (mem_cmd),
        .waitrequest   (waitrequest),
        .readdatavalid (readdatavalid),
        .readdata      (readdata)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t read_memory(input addr_t address);
        if (mem_model.exists(address)) begin
            return mem_model[address];
        end else begin
            return address ^ 32'h5a5a_0000;
        end
    endfunction

    task automatic report_failure(input string msg);
        $display("Simulation FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure("word value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            report_failure("flag value mismatch");
        end
    endtask

    // Starts and ends on a falling edge with the cache idle
    task automatic run_access(input logic [7:0] op, input addr_t addr, input word_t data,
                              input logic hit_exp);
        int base_reads;
        int refill_reads;
        check_flag("busy", busy, 1'b0);
        base_reads = total_reads;
        @(posedge clk);
        req.load       <= (op == "L");
        req.store      <= (op == "S");
        req.address    <= addr;
        req.store_data <= (op == "S") ? data : '0;
        @(posedge clk);
        accepted++;
        req.load  <= 1'b0;
        req.store <= 1'b0;
        @(negedge clk);
        // A hit completes one cycle after the accepting edge
        check_flag("done", done, hit_exp);
        while (!done) begin
            check_flag("busy", busy, 1'b1);
            @(negedge clk);
        end
        if (op == "L") begin
            check_word("load_data", load_data, data);
        end
        refill_reads = total_reads - base_reads;
        if (refill_reads != 0 && refill_reads != LINE_WORDS) begin
            report_failure($sformatf("refill issued %0d reads instead of %0d",
                                     refill_reads, LINE_WORDS));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : memory_model
        logic [31:0] rng;
        logic        rd_xfer;
        logic        wr_xfer;
        mem_cmd_t    cmd;
        int          cycle;
        word_t       ret_data [$];
        int          ret_due [$];
        waitrequest   = 1'b0;
        readdatavalid = 1'b0;
        readdata      = '0;
        rng           = 32'hc50e_4def;
        cycle         = 0;
        forever begin
            // Command is stable by the falling edge
            @(negedge clk);
            cmd     = mem_cmd;
            rd_xfer = rst_n && cmd.read && !waitrequest;
            wr_xfer = rst_n && cmd.write && !waitrequest;
            @(posedge clk);
            cycle++;
            if (wr_xfer) begin
                mem_model[cmd.address] = cmd.writedata;
            end
            if (rd_xfer) begin
                rng = lcg_next(rng);
                ret_data.push_back(read_memory(cmd.address));
                ret_due.push_back(cycle + int'(rng[25:24]));
                total_reads++;
            end
            // Returns leave in issue order
            if (ret_due.size() > 0 && ret_due[0] <= cycle) begin
                readdatavalid <= 1'b1;
                readdata      <= ret_data.pop_front();
                void'(ret_due.pop_front());
            end else begin
                readdatavalid <= 1'b0;
            end
            rng = lcg_next(rng);
            waitrequest <= (rng[18:16] < 3'd3);
        end
    end

    initial begin : bus_monitor
        forever begin
            @(negedge clk);
            if (rst_n) begin
                run_cycles++;
                if (mem_cmd.read && mem_cmd.write) begin
                    report_failure("memory read and write asserted together");
                end
                if (accepted == 0) begin
                    check_flag("busy", busy, 1'b0);
                    check_flag("done", done, 1'b0);
                    check_flag("mem_cmd.read", mem_cmd.read, 1'b0);
                    check_flag("mem_cmd.write", mem_cmd.write, 1'b0);
                end
                if (done) begin
                    if (done_count >= accepted) begin
                        report_failure("done pulsed a second time for one request");
                    end
                    done_count++;
                end
                if (run_cycles > cycle_limit) begin
                    report_failure($sformatf("timeout after %0d cycles", run_cycles));
                end
            end
        end
    end

    initial begin : stimulus
        int         fd;
        int         n;
        int         hit_val;
        string      line;
        logic [7:0] op;
        addr_t      addr;
        word_t      data;
        rst_n = 1'b0;
        req   = '0;
        fd = $fopen("verif/cache_stim.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open verif/cache_stim.txt");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %h %h %d", op, addr, data, hit_val);
            if (n == 4 && op != "#") begin
                if (op != "L" && op != "S") begin
                    report_failure("unknown operation in stimulus file");
                end
                op_q.push_back(op);
                addr_q.push_back(addr);
                data_q.push_back(data);
                hit_q.push_back(hit_val != 0);
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            report_failure("stimulus file holds no accesses");
        end
        cycle_limit = op_q.size() * (2 * LINE_WORDS * 8 + 10);
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < op_q.size(); i++) begin
            run_access(op_q[i], addr_q[i], data_q[i], hit_q[i]);
        end
        // Quiet cycles so a late extra done still shows up
        repeat (2) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/10ps

module cache_top #(
    parameter int ways_w = 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::cpu_req_t  req,
    output logic                 busy,
    output logic                 done,
    output cache_pkg::word_t     load_data,
    output cache_pkg::mem_cmd_t  mem_cmd,
    input  logic                 waitrequest,
    input  logic                 readdatavalid,
    input  cache_pkg::word_t     readdata
);
    import cache_pkg::*;

    logic              hit;
    logic [ways_w-1:0] hit_way;
    logic              victim_valid;
    logic              victim_dirty;
    tag_t              victim_tag;
    logic [ways_w-1:0] victim_way;
    word_t             rd_word;
    offset_t           issue_count;
    offset_t           return_count;
    logic              issue_last;
    logic              return_last;
    logic              lookup_en;
    lane_t             lane;
    offset_t           offset_rd;
    offset_t           offset_wr;
    logic              tag_wr_en;
    logic              data_wr_en;
    logic              dirty_set;
    logic              dirty_clear;
    logic [ways_w-1:0] wr_way;
    word_t             wr_word;
    logic              issue_step;
    logic              return_step;
    logic              count_clear;
    logic              victim_advance;
    tag_t              tag_in;

    // Command address always holds the tag of the access in progress
    assign tag_in = mem_cmd.address[31 -: TAG_W];

    cache_ctrl #(.ways_w(ways_w)) u_ctrl (.*);

    beat_counter #(.ways_w(ways_w)) u_counter (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_step     (issue_step),
        .return_step    (return_step),
        .count_clear    (count_clear),
        .victim_advance (victim_advance),
        .issue_count    (issue_count),
        .return_count   (return_count),
        .issue_last     (issue_last),
        .return_last    (return_last),
        .victim_way     (victim_way)
    );

    tag_store #(.ways_w(ways_w)) u_tags (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_en    (lookup_en),
        .lane         (lane),
        .tag_in       (tag_in),
        .tag_wr_en    (tag_wr_en),
        .dirty_set    (dirty_set),
        .dirty_clear  (dirty_clear),
        .wr_way       (wr_way),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    data_store #(.ways_w(ways_w)) u_data (
        .clk       (clk),
        .rd_en     (lookup_en),
        .lane      (lane),
        .offset_rd (offset_rd),
        .offset_wr (offset_wr),
        .rd_way    (wr_way),
        .wr_en     (data_wr_en),
        .wr_way    (wr_way),
        .wr_word   (wr_word),
        .rd_word   (rd_word)
    );

endmodule

//--- rtl/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl #(
    parameter int ways_w = 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::cpu_req_t  req,
    input  logic                 hit,
    input  logic [ways_w-1:0]    hit_way,
    input  logic                 victim_valid,
    input  logic                 victim_dirty,
    input  cache_pkg::tag_t      victim_tag,
    input  logic [ways_w-1:0]    victim_way,
    input  cache_pkg::word_t     rd_word,
    input  cache_pkg::offset_t   issue_count,
    input  cache_pkg::offset_t   return_count,
    input  logic                 issue_last,
    input  logic                 return_last,
    input  logic                 waitrequest,
    input  logic                 readdatavalid,
    input  cache_pkg::word_t     readdata,
    output logic                 busy,
    output logic                 done,
    output cache_pkg::word_t     load_data,
    output cache_pkg::mem_cmd_t  mem_cmd,
    output logic                 lookup_en,
    output cache_pkg::lane_t     lane,
    output cache_pkg::offset_t   offset_rd,
    output cache_pkg::offset_t   offset_wr,
    output logic                 tag_wr_en,
    output logic                 data_wr_en,
    output logic                 dirty_set,
    output logic                 dirty_clear,
    output logic [ways_w-1:0]    wr_way,
    output cache_pkg::word_t     wr_word,
    output logic                 issue_step,
    output logic                 return_step,
    output logic                 count_clear,
    output logic                 victim_advance
);
    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    cpu_req_t    req_q;
    logic        reads_done;
    logic        accept;
    tag_t        req_tag;
    lane_t       req_lane;
    offset_t     req_offset;

    assign accept     = (state == ST_IDLE) && (req.load || req.store);
    assign req_tag    = req_q.address[31 -: TAG_W];
    assign req_lane   = req_q.address[2 + OFFSET_W +: LANE_W];
    assign req_offset = req_q.address[2 +: OFFSET_W];

    // Index comes straight from the core while idle
    assign lane      = (state == ST_IDLE) ? req.address[2 + OFFSET_W +: LANE_W] : req_lane;
    assign wr_way    = (state == ST_LOOKUP) ? hit_way : victim_way;
    assign wr_word   = (state == ST_REFILL) ? readdata : req_q.store_data;
    assign load_data = rd_word;

    always_comb begin
        state_next     = state;
        busy           = 1'b1;
        done           = 1'b0;
        lookup_en      = 1'b0;
        offset_rd      = req_offset;
        offset_wr      = req_offset;
        tag_wr_en      = 1'b0;
        data_wr_en     = 1'b0;
        dirty_set      = 1'b0;
        dirty_clear    = 1'b0;
        issue_step     = 1'b0;
        return_step    = 1'b0;
        count_clear    = 1'b0;
        victim_advance = 1'b0;
        // Address of the access in progress, which also feeds the tag store
        mem_cmd.read      = 1'b0;
        mem_cmd.write     = 1'b0;
        mem_cmd.address   = {req_q.address[31:2], 2'b00};
        mem_cmd.writedata = rd_word;
        case (state)
            ST_IDLE: begin
                busy            = 1'b0;
                lookup_en       = accept;
                offset_rd       = req.address[2 +: OFFSET_W];
                mem_cmd.address = {req.address[31:2], 2'b00};
                if (accept) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    busy       = 1'b0;
                    done       = 1'b1;
                    data_wr_en = req_q.store;
                    dirty_set  = req_q.store;
                    state_next = ST_IDLE;
                end else if (victim_valid && victim_dirty) begin
                    // Fetch victim word 0 ahead of the first write
                    lookup_en  = 1'b1;
                    offset_rd  = '0;
                    state_next = ST_WRITEBACK;
                end else begin
                    state_next = ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                mem_cmd.write   = 1'b1;
                mem_cmd.address = {victim_tag, req_lane, issue_count, 2'b00};
                if (!waitrequest) begin
                    issue_step = 1'b1;
                    lookup_en  = 1'b1;
                    offset_rd  = issue_count + 1'b1;
                    if (issue_last) begin
                        dirty_clear = 1'b1;
                        count_clear = 1'b1;
                        state_next  = ST_REFILL;
                    end
                end
            end
            ST_REFILL: begin
                mem_cmd.read    = !reads_done;
                mem_cmd.address = {req_tag, req_lane, issue_count, 2'b00};
                issue_step      = !reads_done && !waitrequest;
                offset_wr       = return_count;
                if (readdatavalid) begin
                    return_step = 1'b1;
                    data_wr_en  = 1'b1;
                    if (return_last) begin
                        tag_wr_en      = 1'b1;
                        count_clear    = 1'b1;
                        victim_advance = 1'b1;
                        state_next     = ST_REPLAY;
                    end
                end
            end
            ST_REPLAY: begin
                lookup_en  = 1'b1;
                state_next = ST_LOOKUP;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            reads_done <= 1'b0;
        end else begin
            state <= state_next;
            if (count_clear) begin
                reads_done <= 1'b0;
            end else if (issue_step && issue_last) begin
                reads_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(mem_cmd.read && mem_cmd.write));
    assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy);

endmodule

//--- rtl/data_store.sv
`timescale 1ns/10ps

module data_store #(
    parameter int ways_w = 1
) (
    input  logic                clk,
    input  logic                rd_en,
    input  cache_pkg::lane_t    lane,
    input  cache_pkg::offset_t  offset_rd,
    input  cache_pkg::offset_t  offset_wr,
    input  logic [ways_w-1:0]   rd_way,
    input  logic                wr_en,
    input  logic [ways_w-1:0]   wr_way,
    input  cache_pkg::word_t    wr_word,
    output cache_pkg::word_t    rd_word
);
    import cache_pkg::*;

    localparam int WAYS  = 1 << ways_w;
    localparam int DEPTH = 1 << (LANE_W + OFFSET_W);

    // Word memory per way, addressed by lane then word offset
    word_t mem  [WAYS][DEPTH];
    word_t rd_q [WAYS];

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < WAYS; w++) begin
                rd_q[w] <= mem[w][{lane, offset_rd}];
            end
        end
        if (wr_en) begin
            mem[wr_way][{lane, offset_wr}] <= wr_word;
        end
    end

    // Hit way on lookup, victim way during write-back
    assign rd_word = rd_q[rd_way];

endmodule

//--- rtl/tag_store.sv
`timescale 1ns/10ps

module tag_store #(
    parameter int ways_w = 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               lookup_en,
    input  cache_pkg::lane_t   lane,
    input  cache_pkg::tag_t    tag_in,
    input  logic               tag_wr_en,
    input  logic               dirty_set,
    input  logic               dirty_clear,
    input  logic [ways_w-1:0]  wr_way,
    input  logic [ways_w-1:0]  victim_way,
    output logic               hit,
    output logic [ways_w-1:0]  hit_way,
    output logic               victim_valid,
    output logic               victim_dirty,
    output cache_pkg::tag_t    victim_tag
);
    import cache_pkg::*;

    localparam int WAYS  = 1 << ways_w;
    localparam int LANES = 1 << LANE_W;

    tag_t            tag_mem [WAYS][LANES];
    tag_t            tag_rd  [WAYS];
    logic [WAYS-1:0] valid_q [LANES];
    logic [WAYS-1:0] dirty_q [LANES];
    logic [WAYS-1:0] hit_vec;
    lane_t           lane_q;
    tag_t            tag_q;

    // Tag array, one read per way on lookup
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            tag_q <= tag_in;
            for (int w = 0; w < WAYS; w++) begin
                tag_rd[w] <= tag_mem[w][lane];
            end
        end
        if (tag_wr_en) begin
            tag_mem[wr_way][lane] <= tag_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane_q <= '0;
            for (int l = 0; l < LANES; l++) begin
                valid_q[l] <= '0;
                dirty_q[l] <= '0;
            end
        end else begin
            if (lookup_en) begin
                lane_q <= lane;
            end
            // A freshly refilled line starts clean
            if (tag_wr_en) begin
                valid_q[lane][wr_way] <= 1'b1;
                dirty_q[lane][wr_way] <= 1'b0;
            end else if (dirty_set) begin
                dirty_q[lane][wr_way] <= 1'b1;
            end else if (dirty_clear) begin
                dirty_q[lane][wr_way] <= 1'b0;
            end
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_q[lane_q][w] && (tag_rd[w] == tag_q);
            if (hit_vec[w]) begin
                hit_way = ways_w'(w);
            end
        end
    end

    assign hit          = |hit_vec;
    assign victim_valid = valid_q[lane_q][victim_way];
    assign victim_dirty = dirty_q[lane_q][victim_way];
    assign victim_tag   = tag_rd[victim_way];

    // A refill never leaves the same line in two ways
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit_vec));

endmodule

//--- rtl/beat_counter.sv
`timescale 1ns/10ps

module beat_counter #(
    parameter int ways_w = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue_step,
    input  logic                return_step,
    input  logic                count_clear,
    input  logic                victim_advance,
    output cache_pkg::offset_t  issue_count,
    output cache_pkg::offset_t  return_count,
    output logic                issue_last,
    output logic                return_last,
    output logic [ways_w-1:0]   victim_way
);
    import cache_pkg::*;

    // Extra top bit tells a full line from an empty one
    logic [OFFSET_W:0] issue_q;
    logic [OFFSET_W:0] return_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_q    <= '0;
            return_q   <= '0;
            victim_way <= '0;
        end else begin
            if (count_clear) begin
                issue_q  <= '0;
                return_q <= '0;
            end else begin
                if (issue_step) begin
                    issue_q <= issue_q + 1'b1;
                end
                if (return_step) begin
                    return_q <= return_q + 1'b1;
                end
            end
            // Round robin over the ways
            if (victim_advance) begin
                victim_way <= victim_way + 1'b1;
            end
        end
    end

    assign issue_count  = issue_q[OFFSET_W-1:0];
    assign return_count = return_q[OFFSET_W-1:0];
    assign issue_last   = (issue_q == (OFFSET_W + 1)'(LINE_WORDS - 1));
    assign return_last  = (return_q == (OFFSET_W + 1)'(LINE_WORDS - 1));

    // A returned word always belongs to a read already issued
    assert property (@(posedge clk) disable iff (!rst_n) return_step |-> (return_q < issue_q));

endmodule

//--- rtl/cache_pkg.sv
package cache_pkg;

    // Fixed cache geometry
    localparam int LANE_W     = 4;
    localparam int OFFSET_W   = 2;
    localparam int LINE_WORDS = 1 << OFFSET_W;
    // Address bits left above lane, word offset and byte offset
    localparam int TAG_W      = 32 - LANE_W - OFFSET_W - 2;

    typedef logic [31:0]         word_t;
    typedef logic [31:0]         addr_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [LANE_W-1:0]   lane_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_REPLAY
    } ctrl_state_t;

    // Core request, one word access
    typedef struct packed {
        logic  load;
        logic  store;
        addr_t address;
        word_t store_data;
    } cpu_req_t;

    // Memory command, single word read or write
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        word_t writedata;
    } mem_cmd_t;

endpackage
